//--- rtl/lsm_pkg.sv
package lsm_pkg;

    // --------------------------------------------------
    // Sample format, Q4.12
    // --------------------------------------------------
    localparam int SAMPLE_W    = 16;
    localparam int FRAC_W      = 12;
    localparam int PROD_W      = 2 * SAMPLE_W;
    localparam int MUL_LATENCY = 2;

    // Accumulator and batch sizing
    localparam int ACC_W       = 40;
    localparam int BATCH_SIZE  = 16;
    localparam int N_MOMENTS   = 8;

    // Credit loops
    localparam int RX_DEPTH    = 4;
    localparam int RX_PTR_W    = $clog2(RX_DEPTH);
    localparam int OUT_CREDITS = 2;
    localparam int CREDIT_MAX  = (RX_DEPTH > OUT_CREDITS) ? RX_DEPTH : OUT_CREDITS;

    // --------------------------------------------------
    // Types
    // --------------------------------------------------
    typedef logic signed [SAMPLE_W-1:0]               sample_t;
    typedef logic signed [ACC_W-1:0]                  acc_t;
    typedef logic [2:0]                               moment_idx_t;
    typedef logic [$clog2(BATCH_SIZE+1)-1:0]          batch_cnt_t;
    typedef logic [$clog2(CREDIT_MAX+1)-1:0]          credit_t;

    // Saturation bounds of a product
    localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
    localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

    // Batch control states
    typedef enum logic [1:0] {
        ACCUM,
        SEND,
        CLEAR
    } batch_state_t;

endpackage

//--- rtl/fx_mul.sv
`timescale 1ns/1ps

module fx_mul (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  lsm_pkg::sample_t a,
    input  lsm_pkg::sample_t b,
    output logic             out_valid,
    output lsm_pkg::sample_t product
);

    logic signed [lsm_pkg::PROD_W-1:0] raw_q;
    logic signed [lsm_pkg::PROD_W-1:0] shifted;
    lsm_pkg::sample_t                  sat;
    logic [1:0]                        vld_q;

    // Stage 1, full width product
    always_ff @(posedge clk) begin
        raw_q <= a * b;
    end

    // Drop the fraction bits, then clamp to the sample range
    always_comb begin
        shifted = raw_q >>> lsm_pkg::FRAC_W;
        if (shifted > lsm_pkg::SAMPLE_MAX) begin
            sat = lsm_pkg::SAMPLE_MAX;
        end else if (shifted < lsm_pkg::SAMPLE_MIN) begin
            sat = lsm_pkg::SAMPLE_MIN;
        end else begin
            sat = shifted[lsm_pkg::SAMPLE_W-1:0];
        end
    end

    // Stage 2, saturated result
    always_ff @(posedge clk) begin
        product <= sat;
    end

    // Valid follows the data, no stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[0], in_valid};
        end
    end

    assign out_valid = vld_q[1];

endmodule

//--- rtl/sample_rx_fifo.sv
`timescale 1ns/1ps

module sample_rx_fifo (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  lsm_pkg::sample_t push_x,
    input  lsm_pkg::sample_t push_y,
    input  logic             pop,
    output lsm_pkg::sample_t head_x,
    output lsm_pkg::sample_t head_y,
    output logic             empty,
    output logic             credit
);

    lsm_pkg::sample_t              mem_x [lsm_pkg::RX_DEPTH];
    lsm_pkg::sample_t              mem_y [lsm_pkg::RX_DEPTH];
    logic [lsm_pkg::RX_PTR_W-1:0]  wr_ptr;
    logic [lsm_pkg::RX_PTR_W-1:0]  rd_ptr;
    lsm_pkg::credit_t              count;
    logic                          full;

    assign empty  = (count == '0);
    assign full   = (count == lsm_pkg::credit_t'(lsm_pkg::RX_DEPTH));
    assign head_x = mem_x[rd_ptr];
    assign head_y = mem_y[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem_x[wr_ptr] <= push_x;
            mem_y[wr_ptr] <= push_y;
        end
    end

    // Pointers, fill level and the returned credit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == lsm_pkg::RX_PTR_W'(lsm_pkg::RX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == lsm_pkg::RX_PTR_W'(lsm_pkg::RX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count  <= count + lsm_pkg::credit_t'(push) - lsm_pkg::credit_t'(pop);
            credit <= pop;
        end
    end

    // Upstream must respect its credits
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
        else $error("sample_rx_fifo: push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
        else $error("sample_rx_fifo: pop while empty");

endmodule

//--- rtl/moment_datapath.sv
`timescale 1ns/1ps

module moment_datapath (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 launch,
    input  lsm_pkg::sample_t     x,
    input  lsm_pkg::sample_t     y,
    input  logic                 clear,
    input  lsm_pkg::moment_idx_t sel,
    output logic                 acc_valid,
    output lsm_pkg::acc_t        word
);

    // Head stage results and aligned operands
    logic             head_valid;
    lsm_pkg::sample_t x2;
    lsm_pkg::sample_t xy;
    lsm_pkg::sample_t hx_dly [lsm_pkg::MUL_LATENCY];
    lsm_pkg::sample_t hy_dly [lsm_pkg::MUL_LATENCY];
    lsm_pkg::sample_t x_h;
    lsm_pkg::sample_t y_h;

    // Tail stage results and aligned operands
    lsm_pkg::sample_t x3;
    lsm_pkg::sample_t x2y;
    lsm_pkg::sample_t x4;
    lsm_pkg::sample_t tx_dly   [lsm_pkg::MUL_LATENCY];
    lsm_pkg::sample_t ty_dly   [lsm_pkg::MUL_LATENCY];
    lsm_pkg::sample_t tx2_dly  [lsm_pkg::MUL_LATENCY];
    lsm_pkg::sample_t txy_dly  [lsm_pkg::MUL_LATENCY];

    lsm_pkg::acc_t    term [lsm_pkg::N_MOMENTS];
    lsm_pkg::acc_t    sums [lsm_pkg::N_MOMENTS];

    // --------------------------------------------------
    // Head multipliers
    // --------------------------------------------------
    fx_mul i_mul_xx (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (launch),
        .a         (x),
        .b         (x),
        .out_valid (head_valid),
        .product   (x2)
    );

    fx_mul i_mul_xy (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (launch),
        .a         (x),
        .b         (y),
        .out_valid (),
        .product   (xy)
    );

    // Fixed delay lines, multipliers never stall
    always_ff @(posedge clk) begin
        hx_dly[0]  <= x;
        hy_dly[0]  <= y;
        tx_dly[0]  <= x_h;
        ty_dly[0]  <= y_h;
        tx2_dly[0] <= x2;
        txy_dly[0] <= xy;
        for (int i = 1; i < lsm_pkg::MUL_LATENCY; i++) begin
            hx_dly[i]  <= hx_dly[i-1];
            hy_dly[i]  <= hy_dly[i-1];
            tx_dly[i]  <= tx_dly[i-1];
            ty_dly[i]  <= ty_dly[i-1];
            tx2_dly[i] <= tx2_dly[i-1];
            txy_dly[i] <= txy_dly[i-1];
        end
    end

    assign x_h = hx_dly[lsm_pkg::MUL_LATENCY-1];
    assign y_h = hy_dly[lsm_pkg::MUL_LATENCY-1];

    // --------------------------------------------------
    // Tail multipliers
    // --------------------------------------------------
    fx_mul i_mul_x2x (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (head_valid),
        .a         (x2),
        .b         (x_h),
        .out_valid (acc_valid),
        .product   (x3)
    );

    fx_mul i_mul_x2y (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (head_valid),
        .a         (x2),
        .b         (y_h),
        .out_valid (),
        .product   (x2y)
    );

    fx_mul i_mul_x2x2 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (head_valid),
        .a         (x2),
        .b         (x2),
        .out_valid (),
        .product   (x4)
    );

    // --------------------------------------------------
    // Moment sums, in output word order
    // --------------------------------------------------
    always_comb begin
        term[0] = lsm_pkg::acc_t'(1);
        term[1] = lsm_pkg::acc_t'(tx_dly[lsm_pkg::MUL_LATENCY-1]);
        term[2] = lsm_pkg::acc_t'(tx2_dly[lsm_pkg::MUL_LATENCY-1]);
        term[3] = lsm_pkg::acc_t'(x3);
        term[4] = lsm_pkg::acc_t'(x4);
        term[5] = lsm_pkg::acc_t'(ty_dly[lsm_pkg::MUL_LATENCY-1]);
        term[6] = lsm_pkg::acc_t'(txy_dly[lsm_pkg::MUL_LATENCY-1]);
        term[7] = lsm_pkg::acc_t'(x2y);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sums <= '{default: '0};
        end else if (clear) begin
            sums <= '{default: '0};
        end else if (acc_valid) begin
            for (int k = 0; k < lsm_pkg::N_MOMENTS; k++) begin
                sums[k] <= sums[k] + term[k];
            end
        end
    end

    assign word = sums[sel];

endmodule

//--- rtl/batch_counter.sv
`timescale 1ns/1ps

module batch_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic launch,
    input  logic acc_valid,
    input  logic clear,
    output logic launch_full,
    output logic batch_done
);

    lsm_pkg::batch_cnt_t launch_cnt;
    lsm_pkg::batch_cnt_t done_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            launch_cnt <= '0;
            done_cnt   <= '0;
        end else if (clear) begin
            launch_cnt <= '0;
            done_cnt   <= '0;
        end else begin
            if (launch) begin
                launch_cnt <= launch_cnt + 1'b1;
            end
            if (acc_valid) begin
                done_cnt <= done_cnt + 1'b1;
            end
        end
    end

    assign launch_full = (launch_cnt == lsm_pkg::batch_cnt_t'(lsm_pkg::BATCH_SIZE));
    assign batch_done  = (done_cnt == lsm_pkg::batch_cnt_t'(lsm_pkg::BATCH_SIZE));

    // Pipeline output can only follow what went in
    a_done_le_launch: assert property (@(posedge clk) disable iff (!rst_n)
        done_cnt <= launch_cnt)
        else $error("batch_counter: more accumulations than launches");

endmodule

//--- rtl/batch_fsm.sv
`timescale 1ns/1ps

module batch_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic empty,
    input  logic launch_full,
    input  logic batch_done,
    input  logic send_done,
    output logic launch,
    output logic send_start,
    output logic clear
);

    lsm_pkg::batch_state_t state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= lsm_pkg::ACCUM;
        end else begin
            unique case (state)
                lsm_pkg::ACCUM: begin
                    if (batch_done) begin
                        state <= lsm_pkg::SEND;
                    end
                end
                lsm_pkg::SEND: begin
                    if (send_done) begin
                        state <= lsm_pkg::CLEAR;
                    end
                end
                // Single cycle that zeroes sums and counts
                lsm_pkg::CLEAR: begin
                    state <= lsm_pkg::ACCUM;
                end
                default: begin
                    state <= lsm_pkg::ACCUM;
                end
            endcase
        end
    end

    // Pop from the buffer while the batch still needs samples
    assign launch     = (state == lsm_pkg::ACCUM) && !launch_full && !empty;
    assign send_start = (state == lsm_pkg::ACCUM) && batch_done;
    assign clear      = (state == lsm_pkg::CLEAR);

    a_launch_in_accum: assert property (@(posedge clk) disable iff (!rst_n)
        launch |-> state == lsm_pkg::ACCUM)
        else $error("batch_fsm: launch outside ACCUM");

endmodule

//--- rtl/moment_sender.sv
`timescale 1ns/1ps

module moment_sender (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 send_start,
    input  logic                 moment_credit,
    output lsm_pkg::moment_idx_t sel,
    output logic                 moment_valid,
    output logic                 moment_last,
    output logic                 send_done
);

    lsm_pkg::credit_t credits;
    logic             active;

    // One word per cycle while the solver has room
    assign moment_valid = active && (credits != '0);
    assign moment_last  = moment_valid && (sel == lsm_pkg::moment_idx_t'(lsm_pkg::N_MOMENTS - 1));
    assign send_done    = moment_last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= lsm_pkg::credit_t'(lsm_pkg::OUT_CREDITS);
            active  <= 1'b0;
            sel     <= '0;
        end else begin
            credits <= credits - lsm_pkg::credit_t'(moment_valid)
                               + lsm_pkg::credit_t'(moment_credit);
            if (send_start) begin
                active <= 1'b1;
                sel    <= '0;
            end else if (moment_last) begin
                active <= 1'b0;
                sel    <= '0;
            end else if (moment_valid) begin
                sel <= sel + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Output credit checks
    // --------------------------------------------------
    a_word_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
        moment_valid |-> credits != '0)
        else $error("moment_sender: word sent without credit");

    // Catches a solver that returns more credits than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= lsm_pkg::credit_t'(lsm_pkg::OUT_CREDITS))
        else $error("moment_sender: credit count above OUT_CREDITS");

endmodule

//--- rtl/lsm_accum_top.sv
`timescale 1ns/1ps

module lsm_accum_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sample_valid,
    input  lsm_pkg::sample_t     sample_x,
    input  lsm_pkg::sample_t     sample_y,
    output logic                 sample_credit,
    input  logic                 moment_credit,
    output logic                 moment_valid,
    output lsm_pkg::moment_idx_t moment_idx,
    output logic                 moment_last,
    output lsm_pkg::acc_t        moment_data
);

    lsm_pkg::sample_t head_x;
    lsm_pkg::sample_t head_y;
    logic             empty;
    logic             launch;
    logic             acc_valid;
    logic             clear;
    logic             launch_full;
    logic             batch_done;
    logic             send_start;
    logic             send_done;

    // --------------------------------------------------
    // Input side
    // --------------------------------------------------
    sample_rx_fifo i_rx (
        .clk    (clk),
        .rst_n  (rst_n),
        .push   (sample_valid),
        .push_x (sample_x),
        .push_y (sample_y),
        .pop    (launch),
        .head_x (head_x),
        .head_y (head_y),
        .empty  (empty),
        .credit (sample_credit)
    );

    moment_datapath i_dp (
        .clk       (clk),
        .rst_n     (rst_n),
        .launch    (launch),
        .x         (head_x),
        .y         (head_y),
        .clear     (clear),
        .sel       (moment_idx),
        .acc_valid (acc_valid),
        .word      (moment_data)
    );

    // --------------------------------------------------
    // Batch control and output
    // --------------------------------------------------
    batch_counter i_cnt (
        .clk         (clk),
        .rst_n       (rst_n),
        .launch      (launch),
        .acc_valid   (acc_valid),
        .clear       (clear),
        .launch_full (launch_full),
        .batch_done  (batch_done)
    );

    batch_fsm i_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .empty       (empty),
        .launch_full (launch_full),
        .batch_done  (batch_done),
        .send_done   (send_done),
        .launch      (launch),
        .send_start  (send_start),
        .clear       (clear)
    );

    moment_sender i_snd (
        .clk           (clk),
        .rst_n         (rst_n),
        .send_start    (send_start),
        .moment_credit (moment_credit),
        .sel           (moment_idx),
        .moment_valid  (moment_valid),
        .moment_last   (moment_last),
        .send_done     (send_done)
    );

endmodule

//--- bench/lsm_checker.sv
`timescale 1ns/1ps

module lsm_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sample_valid,
    input  lsm_pkg::sample_t     sample_x,
    input  lsm_pkg::sample_t     sample_y,
    input  logic                 sample_credit,
    input  logic                 moment_credit,
    input  logic                 moment_valid,
    input  lsm_pkg::moment_idx_t moment_idx,
    input  logic                 moment_last,
    input  lsm_pkg::acc_t        moment_data,
    input  logic                 end_of_test,
    output int                   errors,
    output int                   batches
);

    localparam int SAT_HI = (1 << (lsm_pkg::SAMPLE_W - 1)) - 1;
    localparam int SAT_LO = -(1 << (lsm_pkg::SAMPLE_W - 1));

    int     xq [$];
    int     yq [$];
    longint expected [lsm_pkg::N_MOMENTS];
    int     next_idx;
    int     batch_errors;
    int     up_credits;
    int     out_credits;
    int     words;
    int     sat_count;
    logic   reported;

    task automatic report_error(input string msg);
        errors++;
        batch_errors++;
        $display("%s", msg);
    endtask

    // Q4.12 product shifted right and clamped to the sample range
    task automatic model_mul(input int a, input int b, output int p);
        longint full;
        full = longint'(a) * longint'(b);
        full = full >>> lsm_pkg::FRAC_W;
        if (full > SAT_HI) begin
            p = SAT_HI;
            sat_count++;
        end else if (full < SAT_LO) begin
            p = SAT_LO;
            sat_count++;
        end else begin
            p = int'(full);
        end
    endtask

    // --------------------------------------------------
    // Reference sums for the next batch
    // --------------------------------------------------
    task automatic start_batch();
        int x;
        int y;
        int x2;
        int xy;
        int x3;
        int x2y;
        int x4;
        for (int k = 0; k < lsm_pkg::N_MOMENTS; k++) begin
            expected[k] = 0;
        end
        expected[0] = lsm_pkg::BATCH_SIZE;
        if (xq.size() < lsm_pkg::BATCH_SIZE) begin
            report_error($sformatf("batch %0d started with only %0d accepted samples",
                                   batches, xq.size()));
        end
        for (int i = 0; i < lsm_pkg::BATCH_SIZE && xq.size() > 0; i++) begin
            x = xq.pop_front();
            y = yq.pop_front();
            model_mul(x, x, x2);
            model_mul(x, y, xy);
            model_mul(x2, x, x3);
            model_mul(x2, y, x2y);
            model_mul(x2, x2, x4);
            expected[1] += x;
            expected[2] += x2;
            expected[3] += x3;
            expected[4] += x4;
            expected[5] += y;
            expected[6] += xy;
            expected[7] += x2y;
        end
    endtask

    task automatic check_word();
        lsm_pkg::acc_t exp_word;
        if (next_idx == 0) begin
            start_batch();
        end
        exp_word = lsm_pkg::acc_t'(expected[next_idx]);
        if (moment_idx != lsm_pkg::moment_idx_t'(next_idx)) begin
            report_error($sformatf("mismatch moment_idx batch %0d: got %h expected %h",
                                   batches, moment_idx, lsm_pkg::moment_idx_t'(next_idx)));
        end
        if (moment_last != (next_idx == lsm_pkg::N_MOMENTS - 1)) begin
            report_error($sformatf("mismatch moment_last batch %0d idx %0d: got %h expected %h",
                                   batches, next_idx, moment_last,
                                   next_idx == lsm_pkg::N_MOMENTS - 1));
        end
        if (moment_data != exp_word) begin
            report_error($sformatf("mismatch moment_data batch %0d idx %0d: got %h expected %h",
                                   batches, next_idx, moment_data, exp_word));
        end
        words++;
        if (next_idx == lsm_pkg::N_MOMENTS - 1) begin
            if (batch_errors == 0) begin
                $display("batch %0d: ok", batches);
            end else begin
                $display("batch %0d: %0d errors", batches, batch_errors);
            end
            batch_errors = 0;
            batches++;
            next_idx = 0;
        end else begin
            next_idx++;
        end
    endtask

    // Sample at the falling edge where all DUT outputs are settled
    always @(negedge clk) begin
        if (!rst_n) begin
            xq.delete();
            yq.delete();
            errors       = 0;
            batches      = 0;
            next_idx     = 0;
            batch_errors = 0;
            up_credits   = lsm_pkg::RX_DEPTH;
            out_credits  = lsm_pkg::OUT_CREDITS;
            words        = 0;
            sat_count    = 0;
            reported     = 1'b0;
        end else begin
            if (sample_valid) begin
                xq.push_back(int'(sample_x));
                yq.push_back(int'(sample_y));
                up_credits--;
            end
            if (sample_credit) begin
                up_credits++;
            end
            if (up_credits > lsm_pkg::RX_DEPTH) begin
                report_error($sformatf("upstream credits reached %0d, above the buffer depth",
                                       up_credits));
            end

            // Output credit loop
            if (moment_valid && out_credits == 0) begin
                report_error("moment word sent with no output credit left");
            end
            out_credits += int'(moment_credit) - int'(moment_valid);
            if (moment_valid) begin
                check_word();
            end

            if (end_of_test && !reported) begin
                reported = 1'b1;
                if (xq.size() != 0) begin
                    report_error($sformatf("%0d accepted samples never reached a batch",
                                           xq.size()));
                end
                if (next_idx != 0) begin
                    report_error("run ended in the middle of a batch");
                end
                if (sat_count == 0) begin
                    report_error("no product reached saturation");
                end
                $display("batches %0d, words %0d, saturated products %0d, errors %0d",
                         batches, words, sat_count, errors);
            end
        end
    end

endmodule

//--- bench/tb_lsm_accum.sv
`timescale 1ns/1ps

module tb_lsm_accum;

    localparam int          N_BATCHES   = 8;
    localparam int          N_SAMPLES   = N_BATCHES * lsm_pkg::BATCH_SIZE;
    localparam int          CYCLE_LIMIT = N_BATCHES * (lsm_pkg::BATCH_SIZE * 8 + 64);
    localparam logic [31:0] LFSR_SEED   = 32'hd232;
    localparam logic [31:0] LFSR_TAPS   = 32'h80200003;

    logic                 clk;
    logic                 rst_n;
    logic                 sample_valid;
    lsm_pkg::sample_t     sample_x;
    lsm_pkg::sample_t     sample_y;
    logic                 sample_credit;
    logic                 moment_credit;
    logic                 moment_valid;
    lsm_pkg::moment_idx_t moment_idx;
    logic                 moment_last;
    lsm_pkg::acc_t        moment_data;
    logic                 end_of_test;
    int                   errors;
    int                   batches;
    int                   cycles;

    // Driver state
    logic [31:0] lfsr_state;
    int          rx_credits;
    int          sent;
    int          gap;
    int          owed;
    int          credit_wait;

    lsm_accum_top i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_valid  (sample_valid),
        .sample_x      (sample_x),
        .sample_y      (sample_y),
        .sample_credit (sample_credit),
        .moment_credit (moment_credit),
        .moment_valid  (moment_valid),
        .moment_idx    (moment_idx),
        .moment_last   (moment_last),
        .moment_data   (moment_data)
    );

    lsm_checker i_chk (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_valid  (sample_valid),
        .sample_x      (sample_x),
        .sample_y      (sample_y),
        .sample_credit (sample_credit),
        .moment_credit (moment_credit),
        .moment_valid  (moment_valid),
        .moment_idx    (moment_idx),
        .moment_last   (moment_last),
        .moment_data   (moment_data),
        .end_of_test   (end_of_test),
        .errors        (errors),
        .batches       (batches)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------
    // Random source, one LFSR step per bit
    // --------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // One in four values sits near full scale, the rest within +-2.0
    function automatic lsm_pkg::sample_t make_sample();
        int v;
        int off;
        if (take_bits(2) == 0) begin
            off = take_bits(8);
            if (take_bits(1) == 1) begin
                v = -(1 << (lsm_pkg::SAMPLE_W - 1)) + off;
            end else begin
                v = (1 << (lsm_pkg::SAMPLE_W - 1)) - 1 - off;
            end
        end else begin
            v = take_bits(14);
            if (v >= 8192) begin
                v = v - 16384;
            end
        end
        return lsm_pkg::sample_t'(v);
    endfunction

    task automatic observe_outputs();
        if (sample_credit) begin
            rx_credits++;
        end
        if (moment_valid) begin
            owed++;
        end
    endtask

    task automatic drive_sample();
        sample_valid = 1'b0;
        if (gap > 0) begin
            gap--;
        end else if (sent < N_SAMPLES && rx_credits > 0) begin
            sample_x     = make_sample();
            sample_y     = make_sample();
            sample_valid = 1'b1;
            rx_credits--;
            sent++;
            gap = 0;
            if (take_bits(1) == 0) begin
                gap = take_bits(2);
            end
        end
    endtask

    // Slow solver, each credit comes back after 0 to 7 idle cycles
    task automatic return_credit();
        moment_credit = 1'b0;
        if (credit_wait > 0) begin
            credit_wait--;
        end else if (owed > 0) begin
            moment_credit = 1'b1;
            owed--;
            credit_wait = take_bits(3);
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d of %0d batches done",
                 cycles, batches, N_BATCHES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst_n         = 1'b0;
        sample_valid  = 1'b0;
        sample_x      = '0;
        sample_y      = '0;
        moment_credit = 1'b0;
        end_of_test   = 1'b0;
        lfsr_state    = LFSR_SEED;
        rx_credits    = lsm_pkg::RX_DEPTH;
        sent          = 0;
        gap           = 0;
        owed          = 0;
        credit_wait   = 0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        while (batches < N_BATCHES) begin
            @(negedge clk);
            observe_outputs();
            @(posedge clk);
            #1;
            drive_sample();
            return_credit();
        end

        sample_valid  = 1'b0;
        moment_credit = 1'b0;
        end_of_test   = 1'b1;
        @(negedge clk);
        #1;
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- tb.f
rtl/lsm_pkg.sv
rtl/fx_mul.sv
rtl/sample_rx_fifo.sv
rtl/moment_datapath.sv
rtl/batch_counter.sv
rtl/batch_fsm.sv
rtl/moment_sender.sv
rtl/lsm_accum_top.sv
bench/lsm_checker.sv
bench/tb_lsm_accum.sv

//--- Makefile
# Verilator simulation of the moment accumulator

VERILATOR ?= verilator
TOP       ?= tb_lsm_accum
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  := === FAIL ===

SOURCES := $(wildcard rtl/*.sv bench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF -- "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
